//--- common/rnn_pkg.sv
package rnn_pkg;

    // q8.8 signed fixed point, used for activations, weights, biases and sums
    typedef logic signed [15:0] value_t;

    typedef logic [6:0]  token_t;       // vocabulary index, up to 128 symbols
    typedef logic [15:0] param_addr_t;  // parameter memory word address
    typedef logic [6:0]  index_t;       // neuron, embedding or logit index

    typedef enum logic
    {
        DEST_HIDDEN = 1'b0,
        DEST_LOGIT  = 1'b1
    } mac_dest_e;

    // one multiply-accumulate item, aligned with the memory word it uses
    typedef struct packed
    {
        logic      valid;
        logic      is_bias;  // add the word directly
        logic      first;    // starts a new sum
        logic      last;     // closes the sum
        mac_dest_e dest;
        index_t    index;    // target neuron or logit
    } mac_cmd_t;

    typedef struct packed
    {
        logic      valid;
        mac_dest_e dest;
        index_t    index;
        value_t    sum;
    } mac_result_t;

    typedef enum logic [2:0]
    {
        IDLE,
        LOAD_EMBED,
        HIDDEN,
        HIDDEN_DRAIN,
        COMMIT,
        LOGITS,
        LOGIT_DRAIN
    } seq_state_e;

endpackage

//--- datapath/mac_unit.sv
`timescale 1ns/1ps

module mac_unit
    import rnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mac_cmd_t    cmd,
    input  value_t      mem_data,
    input  value_t      operand,
    output mac_result_t result
);

    logic signed [31:0] product;
    value_t             term_value;
    mac_cmd_t           s1_cmd;
    value_t             s1_value;
    value_t             acc;
    value_t             acc_next;

    assign product    = mem_data * operand;
    assign term_value = cmd.is_bias ? mem_data : product[23:8];  // drop 8 fraction bits

    // stage one
    always_ff @(posedge clk)
    begin
        if (reset)
            s1_cmd <= '0;
        else
            s1_cmd <= cmd;
    end

    always_ff @(posedge clk)
    begin
        s1_value <= term_value;
    end

    // stage two, 16-bit wrapping sum
    assign acc_next = (s1_cmd.first ? value_t'(0) : acc) + s1_value;

    always_ff @(posedge clk)
    begin
        if (s1_cmd.valid)
            acc <= acc_next;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            result <= '0;
        else
        begin
            result.valid <= s1_cmd.valid && s1_cmd.last;  // one pulse per finished sum
            result.dest  <= s1_cmd.dest;
            result.index <= s1_cmd.index;
            result.sum   <= acc_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) cmd.last |-> cmd.valid)
        else $error("mac_unit: last flag on an idle command");

endmodule

//--- datapath/state_store.sv
`timescale 1ns/1ps

module state_store
    import rnn_pkg::*;
#(
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        operand_from_embed,
    input  index_t      operand_index,
    output value_t      operand,
    input  logic        embed_wr,
    input  index_t      embed_index,
    input  value_t      mem_data,
    input  mac_result_t result,
    input  logic        commit
);

    localparam int EW = (EMBED_SIZE > 1) ? $clog2(EMBED_SIZE) : 1;
    localparam int HW = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1;

    value_t embed_reg  [EMBED_SIZE];
    value_t new_hidden [HIDDEN_SIZE];
    value_t old_hidden [HIDDEN_SIZE];  // state carried between tokens
    value_t relu_sum;
    logic   hidden_wr;

    assign hidden_wr = result.valid && result.dest == DEST_HIDDEN;
    assign relu_sum  = result.sum[15] ? value_t'(0) : result.sum;  // relu

    always_ff @(posedge clk)
    begin
        if (embed_wr)
            embed_reg[embed_index[EW-1:0]] <= mem_data;
        if (operand_from_embed)
            operand <= embed_reg[operand_index[EW-1:0]];
        else
            operand <= old_hidden[operand_index[HW-1:0]];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < HIDDEN_SIZE; i++)
            begin
                new_hidden[i] <= '0;
                old_hidden[i] <= '0;
            end
        end
        else
        begin
            if (hidden_wr)
                new_hidden[result.index[HW-1:0]] <= relu_sum;
            if (commit)
            begin
                for (int i = 0; i < HIDDEN_SIZE; i++)
                    old_hidden[i] <= new_hidden[i];
            end
        end
    end

endmodule

//--- control/rnn_sequencer.sv
`timescale 1ns/1ps

module rnn_sequencer
    import rnn_pkg::*;
#(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  token_t      token_in,
    output logic        mem_rd,
    output param_addr_t mem_addr,
    output logic        operand_from_embed,
    output index_t      operand_index,
    output logic        embed_wr,
    output index_t      embed_index,
    output mac_cmd_t    cmd,
    input  mac_result_t result,
    output logic        commit,
    output logic        busy
);

    // parameter memory regions, in storage order
    localparam int IH_BASE      = VOCAB_SIZE * EMBED_SIZE;
    localparam int HH_BASE      = IH_BASE + EMBED_SIZE * HIDDEN_SIZE;
    localparam int IB_BASE      = HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int HB_BASE      = IB_BASE + HIDDEN_SIZE;
    localparam int LW_BASE      = HB_BASE + HIDDEN_SIZE;
    localparam int LB_BASE      = LW_BASE + VOCAB_SIZE * HIDDEN_SIZE;
    localparam int PARAM_COUNT  = LB_BASE + VOCAB_SIZE;
    localparam int HIDDEN_TERMS = HIDDEN_SIZE + EMBED_SIZE + 2;

    seq_state_e state;
    token_t     token;
    index_t     neuron;     // hidden neuron or logit being issued
    index_t     term;       // term within the current sum
    logic       last_term;
    logic       bias_term;
    logic       mac_item;

    assign busy     = state != IDLE;
    assign commit   = state == COMMIT;
    assign mac_item = state == HIDDEN || state == LOGITS;

    always_comb
    begin
        mem_rd             = 1'b0;
        mem_addr           = '0;
        operand_from_embed = 1'b0;
        operand_index      = '0;
        last_term          = 1'b0;
        bias_term          = 1'b0;
        case (state)
            LOAD_EMBED:
            begin
                mem_rd    = 1'b1;
                mem_addr  = param_addr_t'(int'(token) * EMBED_SIZE + int'(term));
                last_term = int'(term) == EMBED_SIZE - 1;
            end
            HIDDEN:
            begin
                mem_rd    = 1'b1;
                last_term = int'(term) == HIDDEN_TERMS - 1;
                if (int'(term) < HIDDEN_SIZE)
                begin
                    mem_addr      = param_addr_t'(HH_BASE + int'(neuron) * HIDDEN_SIZE
                                                  + int'(term));
                    operand_index = term;  // old hidden state
                end
                else if (int'(term) == HIDDEN_SIZE)
                begin
                    mem_addr  = param_addr_t'(HB_BASE + int'(neuron));
                    bias_term = 1'b1;
                end
                else if (!last_term)
                begin
                    mem_addr           = param_addr_t'(IH_BASE + int'(neuron) * EMBED_SIZE
                                                       + int'(term) - HIDDEN_SIZE - 1);
                    operand_from_embed = 1'b1;
                    operand_index      = index_t'(int'(term) - HIDDEN_SIZE - 1);
                end
                else
                begin
                    mem_addr  = param_addr_t'(IB_BASE + int'(neuron));
                    bias_term = 1'b1;
                end
            end
            LOGITS:
            begin
                mem_rd    = 1'b1;
                last_term = int'(term) == HIDDEN_SIZE;
                if (last_term)
                begin
                    mem_addr  = param_addr_t'(LB_BASE + int'(neuron));
                    bias_term = 1'b1;
                end
                else
                begin
                    mem_addr      = param_addr_t'(LW_BASE + int'(neuron) * HIDDEN_SIZE
                                                  + int'(term));
                    operand_index = term;  // committed hidden state
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= IDLE;
            token  <= '0;
            neuron <= '0;
            term   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        token  <= token_in;
                        neuron <= '0;
                        term   <= '0;
                        state  <= LOAD_EMBED;
                    end
                end
                LOAD_EMBED:
                begin
                    term <= last_term ? '0 : term + 1'b1;
                    if (last_term)
                        state <= HIDDEN;
                end
                HIDDEN, LOGITS:
                begin
                    term <= last_term ? '0 : term + 1'b1;
                    if (last_term && state == HIDDEN && int'(neuron) == HIDDEN_SIZE - 1)
                    begin
                        neuron <= '0;
                        state  <= HIDDEN_DRAIN;
                    end
                    else if (last_term && state == LOGITS && int'(neuron) == VOCAB_SIZE - 1)
                    begin
                        neuron <= '0;
                        state  <= LOGIT_DRAIN;
                    end
                    else if (last_term)
                        neuron <= neuron + 1'b1;
                end
                HIDDEN_DRAIN:
                begin
                    if (result.valid && result.dest == DEST_HIDDEN
                        && int'(result.index) == HIDDEN_SIZE - 1)
                        state <= COMMIT;
                end
                COMMIT:
                    state <= LOGITS;
                LOGIT_DRAIN:
                begin
                    if (result.valid && result.dest == DEST_LOGIT
                        && int'(result.index) == VOCAB_SIZE - 1)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // command and embedding write follow the read by one cycle, with the data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmd      <= '0;
            embed_wr <= 1'b0;
        end
        else
        begin
            cmd.valid   <= mac_item;
            cmd.is_bias <= bias_term;
            cmd.first   <= mac_item && term == '0;
            cmd.last    <= mac_item && last_term;
            cmd.dest    <= (state == LOGITS) ? DEST_LOGIT : DEST_HIDDEN;
            cmd.index   <= neuron;
            embed_wr    <= state == LOAD_EMBED;
        end
    end

    always_ff @(posedge clk)
    begin
        embed_index <= term;
    end

    assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> int'(mem_addr) < PARAM_COUNT)
        else $error("rnn_sequencer: read address %0d beyond parameter memory", mem_addr);

endmodule

//--- verilog/logit_argmax.sv
`timescale 1ns/1ps

module logit_argmax
    import rnn_pkg::*;
#(
    parameter int VOCAB_SIZE = 76
)
(
    input  logic        clk,
    input  logic        reset,
    input  mac_result_t result,
    output token_t      token_out,
    output logic        token_valid
);

    value_t best_value;
    token_t best_index;
    index_t prev_index;
    logic   logit_in;
    logic   final_logit;
    logic   take;

    assign logit_in    = result.valid && result.dest == DEST_LOGIT;
    assign final_logit = logit_in && int'(result.index) == VOCAB_SIZE - 1;
    // strict compare, so on a tie the lower index stays
    assign take = result.index == '0 || $signed(result.sum) > $signed(best_value);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            token_valid <= 1'b0;
            token_out   <= '0;
            prev_index  <= '0;
        end
        else
        begin
            token_valid <= final_logit;
            if (logit_in)
                prev_index <= result.index;
            if (final_logit)
                token_out <= take ? token_t'(result.index) : best_index;
        end
    end

    always_ff @(posedge clk)
    begin
        if (logit_in && take)
        begin
            best_value <= result.sum;
            best_index <= token_t'(result.index);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        logit_in && result.index != '0 |-> result.index == prev_index + 1'b1)
        else $error("logit_argmax: logit %0d out of order", result.index);

endmodule

//--- verilog/rnn_top.sv
`timescale 1ns/1ps

module rnn_top
    import rnn_pkg::*;
#(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  token_t      token_in,
    output logic        mem_rd,
    output param_addr_t mem_addr,
    input  value_t      mem_data,
    output token_t      token_out,
    output logic        token_valid,
    output logic        busy
);

    logic        operand_from_embed;
    index_t      operand_index;
    value_t      operand;
    logic        embed_wr;
    index_t      embed_index;
    mac_cmd_t    cmd;
    mac_result_t result;
    logic        commit;

    rnn_sequencer #(
        .VOCAB_SIZE  (VOCAB_SIZE),
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) rnn_sequencer_i (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .token_in           (token_in),
        .mem_rd             (mem_rd),
        .mem_addr           (mem_addr),
        .operand_from_embed (operand_from_embed),
        .operand_index      (operand_index),
        .embed_wr           (embed_wr),
        .embed_index        (embed_index),
        .cmd                (cmd),
        .result             (result),
        .commit             (commit),
        .busy               (busy)
    );

    mac_unit mac_unit_i (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .mem_data (mem_data),
        .operand  (operand),
        .result   (result)
    );

    state_store #(
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) state_store_i (
        .clk                (clk),
        .reset              (reset),
        .operand_from_embed (operand_from_embed),
        .operand_index      (operand_index),
        .operand            (operand),
        .embed_wr           (embed_wr),
        .embed_index        (embed_index),
        .mem_data           (mem_data),
        .result             (result),
        .commit             (commit)
    );

    logit_argmax #(
        .VOCAB_SIZE (VOCAB_SIZE)
    ) logit_argmax_i (
        .clk         (clk),
        .reset       (reset),
        .result      (result),
        .token_out   (token_out),
        .token_valid (token_valid)
    );

endmodule

//--- tb/rnn_ref_model.svh
`ifndef RNN_REF_MODEL_SVH
`define RNN_REF_MODEL_SVH

// uses mem and the region bases of the including testbench
value_t model_hidden [HIDDEN_SIZE];  // hidden state kept between tokens

// q8.8 product, arithmetic shift by 8, low 16 bits kept
function automatic value_t q_mul(input value_t a, input value_t b);
    logic signed [31:0] full;
    full = a * b;
    return value_t'(full >>> 8);
endfunction

task automatic model_clear();
    for (int k = 0; k < HIDDEN_SIZE; k++)
        model_hidden[k] = '0;
endtask

// one token through embedding, hidden update, commit and linear layer
task automatic model_step(input int tok, output int best_tok);
    value_t embed [EMBED_SIZE];
    value_t next_hidden [HIDDEN_SIZE];
    value_t sum;
    value_t best;
    for (int j = 0; j < EMBED_SIZE; j++)
        embed[j] = mem[tok * EMBED_SIZE + j];
    for (int n = 0; n < HIDDEN_SIZE; n++)
    begin
        sum = mem[HB_BASE + n] + mem[IB_BASE + n];  // 16-bit wrap
        for (int k = 0; k < HIDDEN_SIZE; k++)
            sum = sum + q_mul(mem[HH_BASE + n * HIDDEN_SIZE + k], model_hidden[k]);
        for (int j = 0; j < EMBED_SIZE; j++)
            sum = sum + q_mul(mem[IH_BASE + n * EMBED_SIZE + j], embed[j]);
        next_hidden[n] = (sum < 0) ? value_t'(0) : sum;  // relu
    end
    for (int n = 0; n < HIDDEN_SIZE; n++)
        model_hidden[n] = next_hidden[n];
    best     = '0;
    best_tok = 0;
    for (int v = 0; v < VOCAB_SIZE; v++)
    begin
        sum = mem[LB_BASE + v];
        for (int k = 0; k < HIDDEN_SIZE; k++)
            sum = sum + q_mul(mem[LW_BASE + v * HIDDEN_SIZE + k], model_hidden[k]);
        if (v == 0 || sum > best)  // lower index wins a tie
        begin
            best     = sum;
            best_tok = v;
        end
    end
endtask

`endif

//--- tb/rnn_tb.sv
`timescale 1ns/1ps

module rnn_tb
    import rnn_pkg::*;
;

    localparam int VOCAB_SIZE  = 76;
    localparam int EMBED_SIZE  = 4;
    localparam int HIDDEN_SIZE = 8;

    // parameter memory layout, embedding table at address zero
    localparam int IH_BASE     = VOCAB_SIZE * EMBED_SIZE;
    localparam int HH_BASE     = IH_BASE + EMBED_SIZE * HIDDEN_SIZE;
    localparam int IB_BASE     = HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int HB_BASE     = IB_BASE + HIDDEN_SIZE;
    localparam int LW_BASE     = HB_BASE + HIDDEN_SIZE;
    localparam int LB_BASE     = LW_BASE + VOCAB_SIZE * HIDDEN_SIZE;
    localparam int PARAM_COUNT = LB_BASE + VOCAB_SIZE;
    localparam int NUM_ROWS    = 8;

    typedef struct packed
    {
        token_t token;
        logic   reset_before;
        logic   start_busy;   // extra start while the engine runs
    } row_t;

    logic        clk;
    logic        reset;
    logic        start;
    token_t      token_in;
    logic        mem_rd;
    param_addr_t mem_addr;
    value_t      mem_data = '0;
    token_t      token_out;
    logic        token_valid;
    logic        busy;

    value_t mem [PARAM_COUNT];
    row_t   rows [NUM_ROWS];
    integer seed = 32'hb52d8207;
    int     checks = 0;
    int     errors = 0;
    int     pulses = 0;

    `include "rnn_ref_model.svh"

    rnn_top rnn_top_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .token_in    (token_in),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .token_out   (token_out),
        .token_valid (token_valid),
        .busy        (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // external memory, one cycle read latency
    always @(posedge clk)
    begin
        if (mem_rd)
            mem_data <= (int'(mem_addr) < PARAM_COUNT) ? mem[mem_addr] : '0;
    end

    always @(negedge clk)
    begin
        if (mem_rd)
            compare_value("mem_addr below param count", int'(mem_addr) < PARAM_COUNT, 1);
        if (token_valid)
            pulses++;
    end

    initial
    begin
        repeat (NUM_ROWS * (PARAM_COUNT + 100)) @(posedge clk);
        $display("timeout: the engine did not report a token in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < PARAM_COUNT; i++)
            mem[i] = value_t'($random(seed) % 129);  // within +-0.5
    endtask

    task automatic load_table();
        rows[0] = '{7'd12, 1'b0, 1'b0};  // fresh state
        rows[1] = '{7'd40, 1'b0, 1'b0};
        rows[2] = '{7'd3,  1'b0, 1'b1};
        rows[3] = '{7'd75, 1'b0, 1'b0};
        rows[4] = '{7'd40, 1'b1, 1'b0};  // reset clears hidden state
        rows[5] = '{7'd0,  1'b0, 1'b1};
        rows[6] = '{7'd63, 1'b0, 1'b0};
        rows[7] = '{7'd12, 1'b1, 1'b1};
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_token(input token_t tok, input logic extra_start);
        @(posedge clk);
        start    <= 1'b1;
        token_in <= tok;
        @(posedge clk);
        start <= 1'b0;
        if (extra_start)
        begin
            repeat (3) @(negedge clk);
            compare_value("busy", busy, 1);
            @(posedge clk);
            start    <= 1'b1;
            token_in <= tok + 7'd1;  // a wrongly taken start would change the result
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (token_valid !== 1'b1)
            @(negedge clk);
    endtask

    initial
    begin
        row_t row;
        int   expected;
        int   accepted;
        reset    = 1'b1;
        start    = 1'b0;
        token_in = '0;
        accepted = 0;
        fill_memory();
        load_table();
        model_clear();
        apply_reset();
        @(negedge clk);
        compare_value("token_valid", token_valid, 0);
        compare_value("mem_rd", mem_rd, 0);
        compare_value("busy", busy, 0);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row = rows[r];
            if (row.reset_before)
            begin
                apply_reset();
                model_clear();
            end
            model_step(int'(row.token), expected);
            run_token(row.token, row.start_busy);
            accepted++;
            compare_value("token_out", token_out, expected);
            @(negedge clk);
            compare_value("token_valid", token_valid, 0);  // single-cycle pulse
            repeat (4) @(negedge clk);
            compare_value("busy", busy, 0);
            compare_value("token_valid pulses", pulses, accepted);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tb
common/rnn_pkg.sv
datapath/mac_unit.sv
datapath/state_store.sv
control/rnn_sequencer.sv
verilog/logit_argmax.sv
verilog/rnn_top.sv
tb/rnn_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f filelist.f --top-module rnn_tb -o rnn_sim &&
./obj_dir/rnn_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
